// ==== design/mist_pkg.sv ====
// Shared pixel, sync and configuration types plus SPI command codes; import where needed
package mist_pkg;

    // One pixel at VGA depth
    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } rgb6_t;

    // Native game pixel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb4_t;

    typedef struct packed {
        logic hs;
        logic vs;
    } sync_t;

    // Settings written over SPI by the I/O controller
    typedef struct packed {
        logic [31:0] status;
        logic [7:0]  joy1;
        logic [7:0]  joy2;
        logic        scandoubler_disable;
        logic        ypbpr;
    } io_cfg_t;

    // Command bytes, first byte of each transfer
    localparam logic [7:0] CMD_BUT_SW = 8'h01;
    localparam logic [7:0] CMD_JOY0   = 8'h02; // Lands in joy2
    localparam logic [7:0] CMD_JOY1   = 8'h03; // Lands in joy1
    localparam logic [7:0] CMD_STATUS = 8'h1E; // Four bytes, LSB first

    // Steering bits inside the button/switch byte
    localparam int BUT_SW_SD_BIT    = 4;
    localparam int BUT_SW_YPBPR_BIT = 5;

endpackage

// ==== design/spi_byte_rx.sv ====
// Oversampled SPI slave receiver; turns the I/O controller bit stream into byte strobes
`timescale 1ns/1ps

module spi_byte_rx #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk_rgb_i,
    input  logic       rst_n_i,
    input  logic       spi_sck_i,
    input  logic       spi_di_i,
    input  logic       spi_ss_n_i,
    output logic [7:0] byte_o,
    output logic       byte_stb_o,
    output logic       first_o
);

    // All three pins share one chain so they stay aligned to each other
    logic [SYNC_STAGES-1:0][2:0] pin_sync_q; // {ss_n, sck, di}
    logic                        ss_n_s;
    logic                        sck_s;
    logic                        di_s;
    logic                        sck_prev_q;
    logic                        sck_rise;
    logic [2:0]                  bit_cnt_q;
    logic                        first_pend_q;
    logic [6:0]                  shift_q;

    assign ss_n_s   = pin_sync_q[SYNC_STAGES-1][2];
    assign sck_s    = pin_sync_q[SYNC_STAGES-1][1];
    assign di_s     = pin_sync_q[SYNC_STAGES-1][0];
    assign sck_rise = sck_s & ~sck_prev_q;

    always_ff @(posedge clk_rgb_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pin_sync_q   <= {SYNC_STAGES{3'b100}}; // Select idles high
            sck_prev_q   <= 1'b0;
            bit_cnt_q    <= 3'd0;
            first_pend_q <= 1'b1;
            byte_stb_o   <= 1'b0;
            first_o      <= 1'b0;
        end else begin
            pin_sync_q <= {pin_sync_q[SYNC_STAGES-2:0], {spi_ss_n_i, spi_sck_i, spi_di_i}};
            sck_prev_q <= sck_s;
            byte_stb_o <= 1'b0;
            first_o    <= 1'b0;
            if (ss_n_s) begin
                bit_cnt_q    <= 3'd0; // Deselect aborts a partial byte
                first_pend_q <= 1'b1;
            end else if (sck_rise) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
                if (bit_cnt_q == 3'd7) begin
                    byte_stb_o   <= 1'b1;
                    first_o      <= first_pend_q;
                    first_pend_q <= 1'b0;
                end
            end
        end
    end

    // Data path, only read together with byte_stb_o
    always_ff @(posedge clk_rgb_i) begin
        if (!ss_n_s && sck_rise) begin
            shift_q <= {shift_q[5:0], di_s};
            if (bit_cnt_q == 3'd7)
                byte_o <= {shift_q, di_s}; // MSB arrived first
        end
    end

endmodule

// ==== design/user_io_regs.sv ====
// Configuration register block; decodes SPI commands into status, joystick and switch settings
`timescale 1ns/1ps

module user_io_regs import mist_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic    clk_rgb_i,
    input  logic    rst_n_i,
    input  logic    spi_sck_i,
    input  logic    spi_di_i,
    input  logic    conf_data0_i,
    output io_cfg_t cfg_o
);

    logic [7:0]  rx_byte;
    logic        rx_stb;
    logic        rx_first;
    logic [7:0]  cmd_q;
    logic [2:0]  data_idx_q;     // Saturates at 4, later bytes are dropped
    logic [23:0] status_shadow_q;
    logic [31:0] status_q;
    logic [7:0]  joy1_q;
    logic [7:0]  joy2_q;
    logic        sd_q;
    logic        ypbpr_q;
    logic        data_stb;

    spi_byte_rx #(
        .SYNC_STAGES ( SYNC_STAGES  )
    ) u_spi_rx (
        .clk_rgb_i   ( clk_rgb_i    ),
        .rst_n_i     ( rst_n_i      ),
        .spi_sck_i   ( spi_sck_i    ),
        .spi_di_i    ( spi_di_i     ),
        .spi_ss_n_i  ( conf_data0_i ),
        .byte_o      ( rx_byte      ),
        .byte_stb_o  ( rx_stb       ),
        .first_o     ( rx_first     )
    );

    assign data_stb = rx_stb & ~rx_first;

    always_ff @(posedge clk_rgb_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd_q      <= 8'd0;
            data_idx_q <= 3'd0;
            status_q   <= 32'd0;
            joy1_q     <= 8'd0;
            joy2_q     <= 8'd0;
            sd_q       <= 1'b0; // Board video after reset
            ypbpr_q    <= 1'b0;
        end else if (rx_stb && rx_first) begin
            cmd_q      <= rx_byte;
            data_idx_q <= 3'd0;
        end else if (data_stb) begin
            if (data_idx_q != 3'd4)
                data_idx_q <= data_idx_q + 3'd1;
            case (cmd_q)
                CMD_BUT_SW: if (data_idx_q == 3'd0) begin
                    sd_q    <= rx_byte[BUT_SW_SD_BIT];
                    ypbpr_q <= rx_byte[BUT_SW_YPBPR_BIT];
                end
                CMD_JOY0:   if (data_idx_q == 3'd0) joy2_q <= rx_byte;
                CMD_JOY1:   if (data_idx_q == 3'd0) joy1_q <= rx_byte;
                CMD_STATUS: if (data_idx_q == 3'd3) status_q <= {rx_byte, status_shadow_q};
                default: ;  // Unknown command
            endcase
        end
    end

    // Lower status bytes wait here until the top byte commits them
    always_ff @(posedge clk_rgb_i) begin
        if (data_stb && cmd_q == CMD_STATUS) begin
            case (data_idx_q)
                3'd0:    status_shadow_q[7:0]   <= rx_byte;
                3'd1:    status_shadow_q[15:8]  <= rx_byte;
                3'd2:    status_shadow_q[23:16] <= rx_byte;
                default: ;
            endcase
        end
    end

    always_comb begin
        cfg_o.status              = status_q;
        cfg_o.joy1                = joy1_q;
        cfg_o.joy2                = joy2_q;
        cfg_o.scandoubler_disable = sd_q;
        cfg_o.ypbpr               = ypbpr_q;
    end

endmodule

// ==== design/rgb2ypbpr.sv ====
// Two-cycle RGB to YPbPr converter in integer arithmetic, used by the video output stage
`timescale 1ns/1ps

module rgb2ypbpr import mist_pkg::*; (
    input  logic       clk_rgb_i,
    input  logic       rst_n_i,
    input  rgb6_t      rgb_i,
    output logic [5:0] y_o,
    output logic [5:0] pb_o,
    output logic [5:0] pr_o
);

    // 13 bits signed covers +-4095, the sums stay within -2016..4032
    logic signed [12:0] r_s;
    logic signed [12:0] g_s;
    logic signed [12:0] b_s;
    logic signed [12:0] y_sum_q;
    logic signed [12:0] pb_sum_q;
    logic signed [12:0] pr_sum_q;
    logic signed [12:0] pb_ofs;
    logic signed [12:0] pr_ofs;

    assign r_s = signed'({7'd0, rgb_i.r});
    assign g_s = signed'({7'd0, rgb_i.g});
    assign b_s = signed'({7'd0, rgb_i.b});

    // Chroma centred at mid scale
    assign pb_ofs = pb_sum_q + 13'sd2048;
    assign pr_ofs = pr_sum_q + 13'sd2048;

    always_ff @(posedge clk_rgb_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            y_sum_q  <= '0;
            pb_sum_q <= '0;
            pr_sum_q <= '0;
            y_o      <= 6'd0;
            pb_o     <= 6'd0;
            pr_o     <= 6'd0;
        end else begin
            y_sum_q  <= 13'sd19 * r_s + 13'sd38 * g_s + 13'sd7 * b_s;
            pb_sum_q <= 13'sd32 * b_s - 13'sd11 * r_s - 13'sd21 * g_s;
            pr_sum_q <= 13'sd32 * r_s - 13'sd27 * g_s - 13'sd5 * b_s;
            y_o      <= y_sum_q[11:6]; // Divide by 64
            pb_o     <= pb_ofs[11:6];
            pr_o     <= pr_ofs[11:6];
        end
    end

endmodule

// ==== design/video_out.sv ====
// VGA output path; picks game or board video, builds syncs and optionally outputs YPbPr
`timescale 1ns/1ps

module video_out import mist_pkg::*; (
    input  logic    clk_rgb_i,
    input  logic    rst_n_i,
    input  io_cfg_t cfg_i,
    input  rgb4_t   game_i,
    input  rgb6_t   board_i,
    input  sync_t   game_sync_i,
    input  sync_t   board_sync_i,
    output rgb6_t   vga_rgb_o,
    output logic    vga_hs_o,
    output logic    vga_vs_o
);

    rgb6_t      sel_rgb;
    sync_t      sel_sync;
    rgb6_t      src_rgb_q;
    sync_t      src_sync_q;
    rgb6_t      dly_rgb_q [2];  // Matches the converter latency
    sync_t      dly_sync_q [2];
    logic [5:0] conv_y;
    logic [5:0] conv_pb;
    logic [5:0] conv_pr;
    logic       csync;
    logic       scart_mode;

    // Native video widened by repeating the top bits, raw syncs are active high
    always_comb begin
        if (cfg_i.scandoubler_disable) begin
            sel_rgb.r   = {game_i.r, game_i.r[3:2]};
            sel_rgb.g   = {game_i.g, game_i.g[3:2]};
            sel_rgb.b   = {game_i.b, game_i.b[3:2]};
            sel_sync.hs = ~game_sync_i.hs;
            sel_sync.vs = ~game_sync_i.vs;
        end else begin
            sel_rgb  = board_i;
            sel_sync = board_sync_i;
        end
    end

    rgb2ypbpr u_rgb2ypbpr (
        .clk_rgb_i ( clk_rgb_i ),
        .rst_n_i   ( rst_n_i   ),
        .rgb_i     ( src_rgb_q ),
        .y_o       ( conv_y    ),
        .pb_o      ( conv_pb   ),
        .pr_o      ( conv_pr   )
    );

    // SCART cables want composite sync on HS and a high VS
    assign csync      = ~(dly_sync_q[1].hs ^ dly_sync_q[1].vs);
    assign scart_mode = cfg_i.scandoubler_disable | cfg_i.ypbpr;

    always_ff @(posedge clk_rgb_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_rgb_q     <= '0;
            src_sync_q    <= '0;
            dly_rgb_q[0]  <= '0;
            dly_rgb_q[1]  <= '0;
            dly_sync_q[0] <= '0;
            dly_sync_q[1] <= '0;
            vga_rgb_o     <= '0;
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
        end else begin
            src_rgb_q     <= sel_rgb;   // Stage 1
            src_sync_q    <= sel_sync;
            dly_rgb_q[0]  <= src_rgb_q; // Stage 2, beside the converter
            dly_sync_q[0] <= src_sync_q;
            dly_rgb_q[1]  <= dly_rgb_q[0];
            dly_sync_q[1] <= dly_sync_q[0];
            if (cfg_i.ypbpr) begin
                vga_rgb_o.r <= conv_pr;
                vga_rgb_o.g <= conv_y;
                vga_rgb_o.b <= conv_pb;
            end else begin
                vga_rgb_o <= dly_rgb_q[1];
            end
            vga_hs_o <= scart_mode ? csync : dly_sync_q[1].hs;
            vga_vs_o <= scart_mode ? 1'b1  : dly_sync_q[1].vs;
        end
    end

endmodule

// ==== design/mist_video_base.sv ====
// Top level of the arcade video base; connects the SPI register block to the VGA output path
`timescale 1ns/1ps

module mist_video_base import mist_pkg::*; #(
    parameter int SYNC_STAGES = 2   // SPI pin synchronizer depth
) (
    input  logic        clk_rgb_i,
    input  logic        rst_n_i,
    input  logic        spi_sck_i,
    input  logic        spi_di_i,
    input  logic        conf_data0_i,
    input  rgb4_t       game_i,
    input  rgb6_t       board_i,
    input  sync_t       game_sync_i,
    input  sync_t       board_sync_i,
    output rgb6_t       vga_rgb_o,
    output logic        vga_hs_o,
    output logic        vga_vs_o,
    output logic [31:0] status_o,
    output logic [7:0]  joystick1_o,
    output logic [7:0]  joystick2_o
);

    io_cfg_t cfg;

    user_io_regs #(
        .SYNC_STAGES  ( SYNC_STAGES  )
    ) u_user_io (
        .clk_rgb_i    ( clk_rgb_i    ),
        .rst_n_i      ( rst_n_i      ),
        .spi_sck_i    ( spi_sck_i    ),
        .spi_di_i     ( spi_di_i     ),
        .conf_data0_i ( conf_data0_i ),
        .cfg_o        ( cfg          )
    );

    video_out u_video (
        .clk_rgb_i    ( clk_rgb_i    ),
        .rst_n_i      ( rst_n_i      ),
        .cfg_i        ( cfg          ),
        .game_i       ( game_i       ),
        .board_i      ( board_i      ),
        .game_sync_i  ( game_sync_i  ),
        .board_sync_i ( board_sync_i ),
        .vga_rgb_o    ( vga_rgb_o    ),
        .vga_hs_o     ( vga_hs_o     ),
        .vga_vs_o     ( vga_vs_o     )
    );

    assign status_o    = cfg.status;
    assign joystick1_o = cfg.joy1;
    assign joystick2_o = cfg.joy2;

endmodule

// ==== bench/tb_spi_tasks.svh ====
// SPI transfer tasks for the testbench; included inside the testbench module body

// One SPI half-period, four clk_rgb cycles, ending on a falling edge
task automatic spi_half();
    repeat (4) @(negedge clk_rgb);
endtask

// MSB first, data set up while the SPI clock is low
task automatic spi_send_byte(input logic [7:0] value);
    int i;
    for (i = 7; i >= 0; i--) begin
        spi_di = value[i];
        spi_half();
        spi_sck = 1'b1; // Receiver samples here
        spi_half();
        spi_sck = 1'b0;
    end
endtask

// Command byte, then nbytes of payload, least significant byte first
task automatic spi_command(input logic [7:0] cmd, input logic [31:0] payload,
                           input int nbytes);
    int i;
    conf_data0 = 1'b0;
    spi_half();
    spi_send_byte(cmd);
    for (i = 0; i < nbytes; i++)
        spi_send_byte(payload[8*i +: 8]);
    spi_half();
    conf_data0 = 1'b1;
    spi_di     = 1'b0;
    // Idle time covers the synchronizer and register delay
    repeat (8) @(negedge clk_rgb);
endtask

// ==== bench/tb_mist_video_base.sv ====
// Testbench for the arcade video base; SPI register writes and a table of video mode runs
`timescale 1ns/1ps

module tb_mist_video_base import mist_pkg::*; ();

    typedef struct packed {
        rgb6_t rgb;
        logic  hs;
        logic  vs;
    } vga_exp_t;

    // Switch byte and number of random pixels per row
    typedef struct packed {
        logic [7:0]  sw_byte;
        logic [15:0] pixels;
    } row_t;

    logic        clk_rgb;
    logic        rst_n;
    logic        spi_sck;
    logic        spi_di;
    logic        conf_data0;
    rgb4_t       game;
    rgb6_t       board;
    sync_t       game_sync;
    sync_t       board_sync;
    rgb6_t       vga_rgb;
    logic        vga_hs;
    logic        vga_vs;
    logic [31:0] status;
    logic [7:0]  joy1;
    logic [7:0]  joy2;

    int          checks;
    int          mismatches;
    int          timeouts;
    vga_exp_t    exp_q [$];

    row_t rows [5] = '{
        '{8'h00, 16'd40},  // Board RGB passthrough
        '{8'h10, 16'd40},  // Native game video
        '{8'h20, 16'd40},  // YPbPr from board
        '{8'h30, 16'd40},  // YPbPr from game
        '{8'hCF, 16'd24}   // Unrelated bits set with the board path
    };

    mist_video_base #(
        .SYNC_STAGES  ( 2          )
    ) dut (
        .clk_rgb_i    ( clk_rgb    ),
        .rst_n_i      ( rst_n      ),
        .spi_sck_i    ( spi_sck    ),
        .spi_di_i     ( spi_di     ),
        .conf_data0_i ( conf_data0 ),
        .game_i       ( game       ),
        .board_i      ( board      ),
        .game_sync_i  ( game_sync  ),
        .board_sync_i ( board_sync ),
        .vga_rgb_o    ( vga_rgb    ),
        .vga_hs_o     ( vga_hs     ),
        .vga_vs_o     ( vga_vs     ),
        .status_o     ( status     ),
        .joystick1_o  ( joy1       ),
        .joystick2_o  ( joy2       )
    );

    always #10 clk_rgb = ~clk_rgb;

    `include "tb_spi_tasks.svh"

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
            mismatches++;
        end
    endtask

    // Polls until the registers settle or 200 cycles pass
    task automatic wait_regs(input logic [31:0] exp_status, input logic [7:0] exp_joy1,
                             input logic [7:0] exp_joy2);
        int n;
        n = 0;
        while ((status !== exp_status || joy1 !== exp_joy1 || joy2 !== exp_joy2) && n < 200) begin
            @(negedge clk_rgb);
            n++;
        end
        if (status !== exp_status || joy1 !== exp_joy1 || joy2 !== exp_joy2) begin
            $display("Timeout: registers did not reach their expected values in 200 cycles");
            timeouts++;
        end
        check("status_o", status, exp_status);
        check("joystick1_o", joy1, exp_joy1);
        check("joystick2_o", joy2, exp_joy2);
    endtask

    // Expected VGA outputs for one pixel in the given mode
    function automatic vga_exp_t predict_vga(input logic sd, input logic yp, input rgb4_t g,
                                             input rgb6_t bd, input sync_t gs, input sync_t bs);
        rgb6_t    src;
        sync_t    sy;
        vga_exp_t e;
        int       r;
        int       gr;
        int       b;
        logic     csync;
        if (sd) begin
            src.r = {g.r, g.r[3:2]};
            src.g = {g.g, g.g[3:2]};
            src.b = {g.b, g.b[3:2]};
            sy.hs = ~gs.hs;
            sy.vs = ~gs.vs;
        end else begin
            src = bd;
            sy  = bs;
        end
        r  = src.r;
        gr = src.g;
        b  = src.b;
        if (yp) begin
            e.rgb.r = 6'((2048 + 32 * r - 27 * gr - 5 * b) / 64);  // Pr
            e.rgb.g = 6'((19 * r + 38 * gr + 7 * b) / 64);         // Y
            e.rgb.b = 6'((2048 - 11 * r - 21 * gr + 32 * b) / 64); // Pb
        end else begin
            e.rgb = src;
        end
        csync = ~(sy.hs ^ sy.vs);
        e.hs  = (sd | yp) ? csync : sy.hs;
        e.vs  = (sd | yp) ? 1'b1 : sy.vs;
        return e;
    endfunction

    // Each output is checked four falling edges after its pixel was driven
    task automatic run_pixels(input logic sd, input logic yp, input int count);
        logic [31:0] r1;
        logic [31:0] r2;
        vga_exp_t    e;
        int          j;
        for (j = 0; j < count + 4; j++) begin
            @(negedge clk_rgb);
            if (exp_q.size() == 4) begin
                e = exp_q.pop_front();
                check("vga_rgb_o.r", vga_rgb.r, e.rgb.r);
                check("vga_rgb_o.g", vga_rgb.g, e.rgb.g);
                check("vga_rgb_o.b", vga_rgb.b, e.rgb.b);
                check("vga_hs_o", vga_hs, e.hs);
                check("vga_vs_o", vga_vs, e.vs);
            end
            r1         = $urandom;
            r2         = $urandom;
            game       = r1[11:0];
            game_sync  = r1[13:12];
            board_sync = r1[15:14];
            board      = r2[17:0];
            exp_q.push_back(predict_vga(sd, yp, r1[11:0], r2[17:0], r1[13:12], r1[15:14]));
        end
        exp_q.delete(); // Tail entries were never due
    endtask

    initial begin
        int i;
        void'($urandom(32'h26384ecb));
        clk_rgb    = 1'b0;
        rst_n      = 1'b0;
        spi_sck    = 1'b0;
        spi_di     = 1'b0;
        conf_data0 = 1'b1;
        game       = '1; // Video inputs busy while reset holds the outputs low
        board      = '1;
        game_sync  = '1;
        board_sync = '1;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;

        repeat (8) @(negedge clk_rgb);
        rst_n = 1'b1;
        check("status_o", status, 32'd0);
        check("joystick1_o", joy1, 8'd0);
        check("joystick2_o", joy2, 8'd0);
        check("vga_rgb_o", vga_rgb, 18'd0);
        check("vga_hs_o", vga_hs, 1'b0);
        check("vga_vs_o", vga_vs, 1'b0);

        spi_command(CMD_STATUS, 32'h12345678, 4);
        wait_regs(32'h12345678, 8'h00, 8'h00);
        spi_command(CMD_JOY0, 32'h000000A5, 1);  // Board swaps the joysticks
        wait_regs(32'h12345678, 8'h00, 8'hA5);
        spi_command(CMD_JOY1, 32'h0000003C, 1);
        wait_regs(32'h12345678, 8'h3C, 8'hA5);
        spi_command(8'h55, 32'hFFFFFFFF, 4);
        wait_regs(32'h12345678, 8'h3C, 8'hA5);
        spi_command(CMD_STATUS, 32'h0000BEEF, 2); // Cut after two bytes
        wait_regs(32'h12345678, 8'h3C, 8'hA5);
        spi_command(CMD_STATUS, 32'h89ABCDEF, 4);
        wait_regs(32'h89ABCDEF, 8'h3C, 8'hA5);

        for (i = 0; i < 5; i++) begin
            spi_command(CMD_BUT_SW, {24'd0, rows[i].sw_byte}, 1);
            run_pixels(rows[i].sw_byte[BUT_SW_SD_BIT], rows[i].sw_byte[BUT_SW_YPBPR_BIT],
                       rows[i].pixels);
        end

        $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
                 checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+bench
design/mist_pkg.sv
design/spi_byte_rx.sv
design/user_io_regs.sv
design/rgb2ypbpr.sv
design/video_out.sv
design/mist_video_base.sv
bench/tb_mist_video_base.sv
